/* rs_core.f */
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rs_fetch.sv
hdl/rs_decode.sv
hdl/rs_regbank.sv
hdl/rs_execute.sv
hdl/rs_core.sv
tb/tb_clk_gen.sv
tb/rs_core_chk.sv
tb/tb_rs_core.sv

/* Bender.yml */
package:
  name: rs_core

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_pipe_pkg.sv
  - hdl/rs_fetch.sv
  - hdl/rs_decode.sv
  - hdl/rs_regbank.sv
  - hdl/rs_execute.sv
  - hdl/rs_core.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/rs_core_chk.sv
      - tb/tb_rs_core.sv

/* tb/tb_rs_core.sv */
`timescale 1ns/1ps

module tb_rs_core;

    localparam int unsigned RomWords  = 64;
    localparam int unsigned ClkPeriod = 20;
    // Room for reset, stalls and the final drain
    localparam int unsigned Margin    = 1000;
    localparam int unsigned NumTests  = 6;
    localparam int unsigned TReset    = 0;
    localparam int unsigned TAlu      = 1;
    localparam int unsigned TX0       = 2;
    localparam int unsigned TBranch   = 3;
    localparam int unsigned TJal      = 4;
    localparam int unsigned TStall    = 5;

    // One expected store tagged with its test
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0]  test;
    } store_t;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        stall_en;
    logic [31:0] instruction;
    logic [31:0] instruction_address;
    logic        mem_req;
    logic [3:0]  mem_be;
    logic [31:0] mem_address;
    logic [31:0] mem_data;

    logic [31:0]  rom [RomWords];
    int unsigned  tag [RomWords];
    logic [31:0]  lfsr = 32'h8246_8e95;
    logic [11:0]  st_off;
    logic [31:0]  final_pc;
    store_t       exp_q [$];
    int unsigned  wr_ptr;
    int unsigned  prog_len = 0;
    int unsigned  exp_total;
    int unsigned  seen = 0;
    int unsigned  stall_cycles = 0;
    int unsigned  checks [NumTests];
    int unsigned  errors [NumTests];
    string        test_name [NumTests] = '{"reset", "alu", "x0_rule", "branch", "jal",
                                           "backpressure"};

    tb_clk_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rs_core #(
        .BootAddr (32'h0)
    ) dut_i (
        .clk                    (clk),
        .rst_n_i                (rst_n),
        .stall_i                (stall),
        .instruction_i          (instruction),
        .instruction_address_o  (instruction_address),
        .mem_operation_enable_o (mem_req),
        .mem_write_enable_o     (mem_be),
        .mem_address_o          (mem_address),
        .mem_data_o             (mem_data)
    );

    // Combinational instruction memory
    assign instruction = rom[instruction_address[7:2]];

    //////////////////////////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders and program
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic void emit(input logic [31:0] ins, input int unsigned t);
        rom[wr_ptr] = ins;
        tag[wr_ptr] = t;
        wr_ptr++;
    endfunction

    // SW rs2 to the next free word off base x0
    function automatic void emit_store(input logic [4:0] rs2, input int unsigned t);
        emit({st_off[11:5], rs2, 5'd0, 3'b010, st_off[4:0], 7'b0100011}, t);
        st_off += 12'd4;
    endfunction

    function automatic void build_program();
        // Opcode 0 fill decodes as a bubble
        for (int i = 0; i < RomWords; i++) begin
            rom[i] = i << 7;
            tag[i] = TStall;
        end
        wr_ptr = 0;
        st_off = 12'h100;
        // Dependent chain where each op needs the bypass
        emit(enc_i(3'b000, 5'd1, 5'd0, 12'(take_bits(12))), TAlu);
        emit(enc_i(3'b000, 5'd2, 5'd1, 12'(take_bits(12))), TAlu);
        emit(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), TAlu);
        emit(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), TAlu);
        emit(enc_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd2), TAlu);
        emit(enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd3), TAlu);
        emit(enc_r(7'h00, 3'b111, 5'd7, 5'd6, 5'd4), TAlu);
        emit(enc_i(3'b100, 5'd8, 5'd7, 12'(take_bits(12))), TAlu);
        emit(enc_i(3'b110, 5'd9, 5'd8, 12'(take_bits(12))), TAlu);
        emit(enc_i(3'b111, 5'd10, 5'd9, 12'(take_bits(12))), TAlu);
        emit({20'(take_bits(20)), 5'd11, 7'b0110111}, TAlu);
        for (int r = 11; r >= 1; r--) begin
            emit_store(5'(r), TAlu);
        end
        // x0 as target and then as source
        emit(enc_i(3'b000, 5'd0, 5'd1, 12'(take_bits(12))), TX0);
        emit(enc_r(7'h00, 3'b000, 5'd0, 5'd2, 5'd3), TX0);
        emit_store(5'd0, TX0);
        // Unknown encoding and SB both act as bubbles
        emit(32'h0000_0000, TX0);
        emit({7'd0, 5'd1, 5'd0, 3'b000, 5'd16, 7'b0100011}, TX0);
        emit(enc_r(7'h00, 3'b000, 5'd13, 5'd0, 5'd1), TX0);
        emit_store(5'd13, TX0);
        // Taken and not-taken branches each followed by a store
        emit(enc_b(3'b000, 5'd1, 5'd1, 13'd8), TBranch);
        emit_store(5'd2, TBranch);
        emit(enc_b(3'b001, 5'd1, 5'd1, 13'd8), TBranch);
        emit_store(5'd3, TBranch);
        emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8), TBranch);
        emit_store(5'd4, TBranch);
        emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8), TBranch);
        emit_store(5'd5, TBranch);
        emit(enc_i(3'b000, 5'd14, 5'd1, 12'd0), TBranch);
        emit(enc_b(3'b000, 5'd14, 5'd1, 13'd8), TBranch);
        emit_store(5'd6, TBranch);
        // Link and skip one store then store the link
        emit(enc_jal(5'd12, 21'd8), TJal);
        emit_store(5'd7, TJal);
        emit_store(5'd12, TJal);
        emit(enc_jal(5'd0, 21'd0), TJal);
        prog_len = wr_ptr;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference ISA model
    //////////////////////////////////////////////////////////////////////
    function automatic void run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [2:0]  f3;
        logic        wr;
        store_t      st;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = '0;
        for (int unsigned steps = 0; steps < RomWords * 4; steps++) begin
            ins   = rom[pc[7:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            f3    = ins[14:12];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            wr    = 1'b1;
            res   = '0;
            npc   = pc + 32'd4;
            case (ins[6:0])
                7'b0010011: begin
                    case (f3)
                        3'b000:  res = a + imm_i;
                        3'b100:  res = a ^ imm_i;
                        3'b110:  res = a | imm_i;
                        3'b111:  res = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110011: begin
                    case ({ins[31:25], f3})
                        {7'h00, 3'b000}: res = a + b;
                        {7'h20, 3'b000}: res = a - b;
                        {7'h00, 3'b100}: res = a ^ b;
                        {7'h00, 3'b110}: res = a | b;
                        {7'h00, 3'b111}: res = a & b;
                        default:         wr = 1'b0;
                    endcase
                end
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0100011: begin
                    wr = 1'b0;
                    if (f3 == 3'b010) begin
                        st.addr = a + imm_s;
                        st.data = b;
                        st.test = 3'(tag[pc[7:2]]);
                        exp_q.push_back(st);
                    end
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                        npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    res = pc + 32'd4;
                    npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            // x0 never changes
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            if (npc == pc) begin
                break;
            end
            pc = npc;
        end
        final_pc = pc;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input int unsigned t, input string what,
                               input logic [31:0] expv, input logic [31:0] act);
        checks[t]++;
        assert (act === expv) else begin
            errors[t]++;
            $display("mismatch %s %s: expected %h, actual %h", test_name[t], what, expv, act);
        end
    endtask

    task automatic check_true(input int unsigned t, input logic cond, input string what);
        checks[t]++;
        assert (cond) else begin
            errors[t]++;
            $display("%s: %s", test_name[t], what);
        end
    endtask

    // Summary line of one finished test
    task automatic report_test(input int unsigned t);
        $display("test %-12s %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
    endtask

    // One LFSR bit pair per cycle and stall on 00
    always @(negedge clk) begin
        stall <= stall_en ? (take_bits(2) == 32'd0) : 1'b0;
    end

    // Accepted store is request high without stall
    always @(posedge clk) begin : compare_stores
        store_t want;
        if (rst_n && stall) begin
            stall_cycles++;
        end
        if (rst_n && mem_req && !stall) begin
            seen++;
            if (exp_q.size() == 0) begin
                check_true(TStall, 1'b0, $sformatf("extra store to %h", mem_address));
            end else begin
                want = exp_q.pop_front();
                check_value(want.test, "address", want.addr, mem_address);
                check_value(want.test, "data", want.data, mem_data);
                // SW always writes the full word
                check_value(want.test, "byte enable", 32'hF, {28'h0, mem_be});
                // Last store of its test
                if (exp_q.size() == 0 || exp_q[0].test != want.test) begin
                    report_test(want.test);
                end
            end
        end
    end

    initial begin : watchdog
        wait (prog_len != 0);
        #(prog_len * 2 * ClkPeriod + Margin);
        $display("Run timed out with %0d stores still outstanding", exp_q.size());
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        int unsigned quiet;
        int unsigned total_checks;
        int unsigned total_errors;
        stall    = 1'b0;
        stall_en = 1'b0;
        build_program();
        run_model();
        exp_total = exp_q.size();
        // PC is unknown before the first reset edge
        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
            check_value(TReset, "pc", 32'h0, instruction_address);
            check_value(TReset, "request", 32'h0, {31'h0, mem_req});
        end
        report_test(TReset);
        stall_en = 1'b1;
        wait (seen == exp_total);
        // Let the final self-loop spin to expose any late store
        quiet = 0;
        while (quiet < 4) begin
            @(posedge clk);
            if (!stall && instruction_address == final_pc) begin
                quiet++;
            end
        end
        @(negedge clk);
        check_value(TStall, "store count", exp_total, seen);
        check_true(TStall, stall_cycles > 0, "stall_i was never asserted");
        report_test(TStall);
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NumTests; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("total %0d checks, %0d errors, %0d assertion failures, %0d stall cycles",
                 total_checks, total_errors, dut_i.chk_i.fail_cnt, stall_cycles);
        if (total_errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb/rs_core_chk.sv */
`timescale 1ns/1ps

module rs_core_chk (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          stall_i,
    input logic                          req_i,
    input logic [3:0]                    be_i,
    input logic [rv_isa_pkg::XLEN-1:0]   addr_i,
    input logic [rv_isa_pkg::XLEN-1:0]   data_i
);

    // Number of failed assertions
    int unsigned fail_cnt = 0;

    // Stalled store stays on the port unchanged
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i && stall_i |=> req_i && $stable(addr_i) && $stable(data_i) && $stable(be_i))
    else begin
        fail_cnt++;
        $error("store request changed while stall_i was high");
    end

    // Word stores only
    be_word: assert property (@(posedge clk) disable iff (!rst_n_i)
        be_i == 4'h0 || be_i == 4'hF)
    else begin
        fail_cnt++;
        $error("byte enable is neither zero nor all ones");
    end

    // Pipeline still empty right after reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !req_i ##1 !req_i)
    else begin
        fail_cnt++;
        $error("store request made right after reset release");
    end

endmodule

bind rs_core rs_core_chk chk_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .req_i   (mem_operation_enable_o),
    .be_i    (mem_write_enable_o),
    .addr_i  (mem_address_o),
    .data_i  (mem_data_o)
);

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned HalfPeriod  = 10,
    parameter int unsigned ResetCycles = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HalfPeriod) clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* hdl/rs_core.sv */
`timescale 1ns/1ps

module rs_core #(
    parameter logic [rv_isa_pkg::XLEN-1:0] BootAddr = '0
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   instruction_i,
    output logic [rv_isa_pkg::XLEN-1:0]   instruction_address_o,
    output logic                          mem_operation_enable_o,
    output logic [3:0]                    mem_write_enable_o,
    output logic [rv_isa_pkg::XLEN-1:0]   mem_address_o,
    output logic [rv_isa_pkg::XLEN-1:0]   mem_data_o
);

    logic [rv_isa_pkg::XLEN-1:0] pc_fetch;
    rv_pipe_pkg::jump_t          jump;
    rv_pipe_pkg::dec_instr_t     dec;
    rv_pipe_pkg::mem_req_t       mem_req;

    //////////////////////////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////////////////////////
    rs_fetch #(
        .BootAddr (BootAddr)
    ) fetch_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .jump_i   (jump),
        .pc_o     (pc_fetch)
    );

    rs_decode decode_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .jump_i        (jump),
        .instruction_i (instruction_i),
        .pc_i          (pc_fetch),
        .dec_o         (dec)
    );

    rs_execute execute_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .dec_i    (dec),
        .jump_o   (jump),
        .mem_o    (mem_req)
    );

    // Memory ports
    assign instruction_address_o  = pc_fetch;
    // Only stores reach the data port
    assign mem_operation_enable_o = mem_req.we;
    assign mem_write_enable_o     = mem_req.be;
    assign mem_address_o          = mem_req.addr;
    assign mem_data_o             = mem_req.wdata;

endmodule

/* hdl/rs_execute.sv */
`timescale 1ns/1ps

module rs_execute (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       stall_i,
    input  rv_pipe_pkg::dec_instr_t    dec_i,
    output rv_pipe_pkg::jump_t         jump_o,
    output rv_pipe_pkg::mem_req_t      mem_o
);

    localparam logic [rv_isa_pkg::XLEN-1:0] InstrBytes = 'd4;

    logic [rv_isa_pkg::XLEN-1:0] rf_data1;
    logic [rv_isa_pkg::XLEN-1:0] rf_data2;
    logic [rv_isa_pkg::XLEN-1:0] op_a;
    logic [rv_isa_pkg::XLEN-1:0] rs2_val;
    logic [rv_isa_pkg::XLEN-1:0] op_b;
    logic [rv_isa_pkg::XLEN-1:0] alu_res;
    logic                        writes_rd;
    logic                        is_store;
    rv_pipe_pkg::retire_t        ret_d;
    rv_pipe_pkg::retire_t        ret_q;
    rv_pipe_pkg::mem_req_t       mem_d;
    rv_pipe_pkg::mem_req_t       mem_q;

    // Bank is written from the retire slot
    rs_regbank regbank_i (
        .clk     (clk),
        .rs1_i   (dec_i.rs1),
        .rs2_i   (dec_i.rs2),
        .wr_i    (ret_q),
        .data1_o (rf_data1),
        .data2_o (rf_data2)
    );

    //////////////////////////////////////////////////////////////////////
    // Operand bypass
    //////////////////////////////////////////////////////////////////////
    // Retire slot result is one write ahead of the bank
    assign op_a    = (ret_q.we && ret_q.rd != '0 && ret_q.rd == dec_i.rs1)
                     ? ret_q.result : rf_data1;
    assign rs2_val = (ret_q.we && ret_q.rd != '0 && ret_q.rd == dec_i.rs2)
                     ? ret_q.result : rf_data2;
    // I-type has rs2 = x0, R-type has imm = 0
    assign op_b    = rs2_val | dec_i.imm;

    // ALU
    always_comb begin
        case (dec_i.op)
            rv_isa_pkg::OP_ADD: alu_res = op_a + op_b;
            rv_isa_pkg::OP_SUB: alu_res = op_a - op_b;
            rv_isa_pkg::OP_AND: alu_res = op_a & op_b;
            rv_isa_pkg::OP_OR:  alu_res = op_a | op_b;
            rv_isa_pkg::OP_XOR: alu_res = op_a ^ op_b;
            rv_isa_pkg::OP_LUI: alu_res = dec_i.imm;
            // Link address
            rv_isa_pkg::OP_JAL: alu_res = dec_i.pc + InstrBytes;
            default:            alu_res = '0;
        endcase
    end

    assign writes_rd = dec_i.valid && (dec_i.op inside {
                           rv_isa_pkg::OP_ADD, rv_isa_pkg::OP_SUB, rv_isa_pkg::OP_AND,
                           rv_isa_pkg::OP_OR, rv_isa_pkg::OP_XOR, rv_isa_pkg::OP_LUI,
                           rv_isa_pkg::OP_JAL});
    assign is_store  = dec_i.valid && dec_i.op == rv_isa_pkg::OP_SW;

    //////////////////////////////////////////////////////////////////////
    // Branch resolution
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        jump_o.taken  = dec_i.valid && ((dec_i.op == rv_isa_pkg::OP_JAL)
                        || (dec_i.op == rv_isa_pkg::OP_BEQ && op_a == rs2_val)
                        || (dec_i.op == rv_isa_pkg::OP_BNE && op_a != rs2_val));
        // Same pc-relative target for JAL and branches
        jump_o.target = dec_i.pc + dec_i.imm;
    end

    //////////////////////////////////////////////////////////////////////
    // Retire slot and store request
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ret_d.we     = writes_rd;
        ret_d.rd     = dec_i.rd;
        ret_d.result = alu_res;
        mem_d.we     = is_store;
        mem_d.addr   = op_a + dec_i.imm;
        mem_d.wdata  = rs2_val;
        // Full word or nothing
        mem_d.be     = is_store ? 4'hF : 4'h0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ret_q.we <= 1'b0;
            ret_q.rd <= '0;
            mem_q.we <= 1'b0;
            mem_q.be <= 4'h0;
        end else if (!stall_i) begin
            ret_q <= ret_d;
            mem_q <= mem_d;
        end
    end

    assign mem_o = mem_q;

endmodule

/* hdl/rs_regbank.sv */
`timescale 1ns/1ps

module rs_regbank (
    input  logic                                clk,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2_i,
    input  rv_pipe_pkg::retire_t                wr_i,
    output logic [rv_isa_pkg::XLEN-1:0]         data1_o,
    output logic [rv_isa_pkg::XLEN-1:0]         data2_o
);

    // x1..x31 only, x0 has no storage
    logic [rv_isa_pkg::XLEN-1:0] regs [1:31];

    // Single write port, x0 writes dropped
    always_ff @(posedge clk) begin
        if (wr_i.we && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.result;
        end
    end

    // Asynchronous reads
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* hdl/rs_decode.sv */
`timescale 1ns/1ps

module rs_decode (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  rv_pipe_pkg::jump_t            jump_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   instruction_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   pc_i,
    output rv_pipe_pkg::dec_instr_t       dec_o
);

    logic [rv_isa_pkg::XLEN-1:0] instr;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    rv_pipe_pkg::dec_instr_t     dec_d;
    rv_pipe_pkg::dec_instr_t     dec_q;

    // Wrong-path slot is replaced by the canonical NOP
    assign instr  = jump_i.taken ? rv_isa_pkg::NOP_INSTR : instruction_i;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    //////////////////////////////////////////////////////////////////////
    // Instruction decoder
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        dec_d       = '0;
        dec_d.valid = ~jump_i.taken;
        dec_d.op    = rv_isa_pkg::OP_NOP;
        dec_d.rd    = instr[11:7];
        dec_d.rs1   = instr[19:15];
        dec_d.rs2   = instr[24:20];
        dec_d.pc    = pc_i;

        case (rv_isa_pkg::opcode_e'(instr[6:0]))
            rv_isa_pkg::OPC_OP_IMM: begin
                // rs2 cleared, second ALU operand becomes imm alone
                dec_d.rs2 = '0;
                dec_d.imm = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    rv_isa_pkg::F3_ADD: dec_d.op = rv_isa_pkg::OP_ADD;
                    rv_isa_pkg::F3_XOR: dec_d.op = rv_isa_pkg::OP_XOR;
                    rv_isa_pkg::F3_OR:  dec_d.op = rv_isa_pkg::OP_OR;
                    rv_isa_pkg::F3_AND: dec_d.op = rv_isa_pkg::OP_AND;
                    default:            dec_d.op = rv_isa_pkg::OP_NOP;
                endcase
            end
            rv_isa_pkg::OPC_OP: begin
                // imm stays zero here
                if (funct7 == rv_isa_pkg::F7_BASE) begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD: dec_d.op = rv_isa_pkg::OP_ADD;
                        rv_isa_pkg::F3_XOR: dec_d.op = rv_isa_pkg::OP_XOR;
                        rv_isa_pkg::F3_OR:  dec_d.op = rv_isa_pkg::OP_OR;
                        rv_isa_pkg::F3_AND: dec_d.op = rv_isa_pkg::OP_AND;
                        default:            dec_d.op = rv_isa_pkg::OP_NOP;
                    endcase
                end else if (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD) begin
                    dec_d.op = rv_isa_pkg::OP_SUB;
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                dec_d.op  = rv_isa_pkg::OP_LUI;
                dec_d.imm = {instr[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_STORE: begin
                if (funct3 == rv_isa_pkg::F3_SW) begin
                    dec_d.op = rv_isa_pkg::OP_SW;
                end
                dec_d.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (funct3 == rv_isa_pkg::F3_BEQ) begin
                    dec_d.op = rv_isa_pkg::OP_BEQ;
                end else if (funct3 == rv_isa_pkg::F3_BNE) begin
                    dec_d.op = rv_isa_pkg::OP_BNE;
                end
                dec_d.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
            end
            rv_isa_pkg::OPC_JAL: begin
                dec_d.op  = rv_isa_pkg::OP_JAL;
                dec_d.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
            end
            default: dec_d.op = rv_isa_pkg::OP_NOP;
        endcase

        // Stores, branches and unknowns write nothing
        if (dec_d.op inside {rv_isa_pkg::OP_NOP, rv_isa_pkg::OP_SW,
                             rv_isa_pkg::OP_BEQ, rv_isa_pkg::OP_BNE}) begin
            dec_d.rd = '0;
        end
    end

    // Decode register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
            dec_q.op    <= rv_isa_pkg::OP_NOP;
            dec_q.rd    <= '0;
        end else if (!stall_i) begin
            dec_q <= dec_d;
        end
    end

    assign dec_o = dec_q;

endmodule

/* hdl/rs_fetch.sv */
`timescale 1ns/1ps

module rs_fetch #(
    parameter logic [rv_isa_pkg::XLEN-1:0] BootAddr = '0
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  rv_pipe_pkg::jump_t            jump_i,
    output logic [rv_isa_pkg::XLEN-1:0]   pc_o
);

    // One 32-bit instruction per fetch
    localparam logic [rv_isa_pkg::XLEN-1:0] InstrBytes = 'd4;

    logic [rv_isa_pkg::XLEN-1:0] pc_q;
    logic [rv_isa_pkg::XLEN-1:0] pc_d;

    // Redirect wins over sequential fetch
    always_comb begin
        if (jump_i.taken) begin
            pc_d = jump_i.target;
        end else begin
            pc_d = pc_q + InstrBytes;
        end
    end

    // Program counter
    // held while stalled, so the address stays on the port
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= BootAddr;
        end else if (!stall_i) begin
            pc_q <= pc_d;
        end
    end

    // Same value serves as instruction address and decode pc
    assign pc_o = pc_q;

endmodule

/* hdl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // Decode register contents, decode to execute
    typedef struct packed {
        logic                                valid;
        rv_isa_pkg::op_e                     op;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2;
        // Sign-extended, or upper-aligned for LUI
        logic [rv_isa_pkg::XLEN-1:0]         imm;
        logic [rv_isa_pkg::XLEN-1:0]         pc;
    } dec_instr_t;

    // Redirect from execute back to fetch and decode
    typedef struct packed {
        logic                                taken;
        logic [rv_isa_pkg::XLEN-1:0]         target;
    } jump_t;

    // Retire slot, also the register bank write port
    typedef struct packed {
        logic                                we;
        logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd;
        logic [rv_isa_pkg::XLEN-1:0]         result;
    } retire_t;

    // Store request toward data memory
    typedef struct packed {
        logic                                we;
        logic [rv_isa_pkg::XLEN-1:0]         addr;
        logic [rv_isa_pkg::XLEN-1:0]         wdata;
        logic [3:0]                          be;
    } mem_req_t;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Datapath and address width
    localparam int unsigned XLEN       = 32;
    // Register index width
    localparam int unsigned REG_ADDR_W = 5;

    // Major opcode, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // funct3 of the ALU groups
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    // funct3 of the kept branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    // Word store only, SB and SH fall to NOP
    localparam logic [2:0] F3_SW  = 3'b010;

    // funct7 of register-register ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Decoded operation
    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_LUI, OP_SW, OP_BEQ, OP_BNE, OP_JAL
    } op_e;

    // ADDI x0,x0,0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage
